/* hdl/fetch_sequencer.sv */
`default_nettype none

`include "nn_classifier_defines.svh"

module fetch_sequencer (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire                          clr,
    output nn_classifier_pkg::mem_rd_t   fetch_rd,
    output nn_classifier_pkg::mac_ctrl_t mac_ctrl,
    input  wire                          scores_valid,
    output logic                         ready,
    output logic                         done
);
    import nn_classifier_pkg::*;

    seq_state_e             state;
    logic [`NN_ADDR_W-1:0]  row_cnt;   // Doubles as read address
    logic                   accept;

    assign ready  = (state == IDLE);
    assign accept = start && ready;    // Start while busy is dropped

    // One request feeds both memories
    always_comb
    begin
        fetch_rd.en   = (state == FETCH) || (state == BIAS);
        fetch_rd.addr = row_cnt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
        begin
            state   <= IDLE;
            row_cnt <= '0;
            done    <= 1'b0;
        end
        else if (clr)
        begin
            state   <= IDLE;   // Abort, no done
            row_cnt <= '0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        state   <= FETCH;
                        row_cnt <= '0;
                    end
                end
                FETCH:
                begin
                    row_cnt <= row_cnt + 1'b1;   // Lands on the bias row after 8
                    if (row_cnt == `NN_FEATURES - 1)
                        state <= BIAS;
                end
                BIAS:  state <= SCORE;           // Bias read in flight
                SCORE: state <= STORE;           // Array adds bias this cycle
                STORE:
                begin
                    if (done)
                        state <= IDLE;
                    else if (scores_valid)
                        done <= 1'b1;            // Buffer written on this edge
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Control one stage late, lines up with the read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mac_ctrl <= '0;
        else
        begin
            mac_ctrl.acc_clear <= clr || accept;
            mac_ctrl.acc_en    <= !clr && (state == FETCH);
            mac_ctrl.bias_en   <= !clr && (state == BIAS);
        end
    end

    // Array answers on the first STORE cycle
    a_score_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (state == SCORE) |=> scores_valid);

    // No score pulse outside the store wait, except right after an abort
    a_no_stray_scores: assert property (@(posedge clk) disable iff (!rst_n)
        scores_valid |-> (state == STORE) || $past(clr));

endmodule

`default_nettype wire

/* hdl/neuron_mac_array.sv */
`default_nettype none

`include "nn_classifier_defines.svh"

module neuron_mac_array (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire nn_classifier_pkg::row_t sample_row,
    input  wire nn_classifier_pkg::row_t weight_row,
    input  wire nn_classifier_pkg::mac_ctrl_t mac_ctrl,
    output nn_classifier_pkg::row_t      scores,
    output logic                         scores_valid
);
    import nn_classifier_pkg::*;

    localparam logic signed [`NN_ACC_W-1:0] SAT_MAX = 2**(`NN_WORD_W-1) - 1;

    logic [`NN_ROW_W-1:0]         x_bits;
    logic [`NN_ROW_W-1:0]         w_bits;
    logic [`NN_ROW_W-1:0]         act_bits;   // Packed next scores
    lane_word_t                   x_lane  [`NN_LANES];
    lane_word_t                   w_lane  [`NN_LANES];   // Weight, or bias on the last row
    logic signed [`NN_ACC_W-1:0]  prod    [`NN_LANES];
    logic signed [`NN_ACC_W-1:0]  acc     [`NN_LANES];
    logic signed [`NN_ACC_W-1:0]  biased  [`NN_LANES];
    logic signed [`NN_ACC_W-1:0]  shifted [`NN_LANES];

    assign x_bits = sample_row;
    assign w_bits = weight_row;

    always_comb
    begin
        for (int i = 0; i < `NN_LANES; i++)
        begin
            // Lane 0 sits in the top word
            x_lane[i] = x_bits[`NN_ROW_W-1-i*`NN_WORD_W -: `NN_WORD_W];
            w_lane[i] = w_bits[`NN_ROW_W-1-i*`NN_WORD_W -: `NN_WORD_W];
            prod[i]   = x_lane[i] * w_lane[i];   // Q16.16, full width
            // Bias up to Q16.16 before adding
            biased[i]  = acc[i] + (`NN_ACC_W'(w_lane[i]) <<< `NN_FRAC_BITS);
            shifted[i] = biased[i] >>> `NN_FRAC_BITS;   // Back to Q8.8
            // ReLU also covers the low saturation bound
            if (shifted[i] < 0)
                act_bits[`NN_ROW_W-1-i*`NN_WORD_W -: `NN_WORD_W] = '0;
            else if (shifted[i] > SAT_MAX)
                act_bits[`NN_ROW_W-1-i*`NN_WORD_W -: `NN_WORD_W] = SAT_MAX[`NN_WORD_W-1:0];
            else
                act_bits[`NN_ROW_W-1-i*`NN_WORD_W -: `NN_WORD_W] = shifted[i][`NN_WORD_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
        begin
            for (int i = 0; i < `NN_LANES; i++)
                acc[i] <= '0;
        end
        else if (mac_ctrl.acc_clear)
        begin
            for (int i = 0; i < `NN_LANES; i++)
                acc[i] <= '0;
        end
        else if (mac_ctrl.acc_en)
        begin
            for (int i = 0; i < `NN_LANES; i++)
                acc[i] <= acc[i] + prod[i];
        end
    end

    // Scores one cycle after bias_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            scores_valid <= 1'b0;
        else
            scores_valid <= mac_ctrl.bias_en;
    end

    always_ff @(posedge clk)
    begin
        if (mac_ctrl.bias_en)
            scores <= act_bits;
    end

endmodule

`default_nettype wire

/* hdl/nn_classifier_defines.svh */
`ifndef NN_CLASSIFIER_DEFINES_SVH
`define NN_CLASSIFIER_DEFINES_SVH

// Lane and row geometry
`define NN_LANES       4       // Class lanes per row
`define NN_WORD_W      16      // Q8.8 lane word
`define NN_ROW_W       64      // One memory row
`define NN_BYTES       8       // Byte enables per row

// Operand memory map
`define NN_ADDR_W      4
`define NN_FEATURES    9       // Feature rows 0..8
`define NN_BIAS_ROW    9       // Biases follow the weights

// Arithmetic
`define NN_FRAC_BITS   8
`define NN_ACC_W       40      // Headroom for nine 32-bit products
`define NN_RES_ADDR_W  2

`endif

/* hdl/nn_classifier_pkg.sv */
`default_nettype none

`include "nn_classifier_defines.svh"

package nn_classifier_pkg;

    typedef logic signed [`NN_WORD_W-1:0] lane_word_t;   // Signed Q8.8

    // Lane 0 in the top bits, same order as class_e
    typedef struct packed {
        lane_word_t dos;
        lane_word_t portscan;
        lane_word_t ddos;
        lane_word_t patator;
    } row_t;

    typedef struct packed {
        logic                   en;
        logic [`NN_BYTES-1:0]   byte_we;
        logic [`NN_ADDR_W-1:0]  addr;
        row_t                   data;
    } mem_wr_t;

    typedef struct packed {
        logic                   en;
        logic [`NN_ADDR_W-1:0]  addr;
    } mem_rd_t;

    typedef struct packed {
        logic acc_clear;   // Zero all accumulators
        logic acc_en;      // Add one product per lane
        logic bias_en;     // Add bias and produce scores
    } mac_ctrl_t;

    // Lane index, doubles as result address
    typedef enum logic [`NN_RES_ADDR_W-1:0] {DOS, PORTSCAN, DDOS, PATATOR} class_e;

    typedef enum logic [2:0] {IDLE, FETCH, BIAS, SCORE, STORE} seq_state_e;

endpackage

`default_nettype wire

/* hdl/nn_classifier_top.sv */
`default_nettype none

`include "nn_classifier_defines.svh"

module nn_classifier_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            clr,
    input  wire                            start,
    output wire                            ready,
    output wire                            done,
    input  wire nn_classifier_pkg::mem_wr_t sample_wr,
    input  wire nn_classifier_pkg::mem_wr_t weight_wr,
    input  wire                            result_rd_en,
    input  wire nn_classifier_pkg::class_e result_addr,
    output nn_classifier_pkg::lane_word_t  result_data
);
    import nn_classifier_pkg::*;

    mem_rd_t    fetch_rd;       // Shared row request
    row_t       sample_row;
    row_t       weight_row;
    mac_ctrl_t  mac_ctrl;
    row_t       scores;
    logic       scores_valid;

    // Features only, rows 0..8
    operand_bram #(.DEPTH(`NN_FEATURES)) u_sample_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (sample_wr),
        .rd      (fetch_rd),
        .rd_data (sample_row)
    );

    // Weights plus bias row
    operand_bram #(.DEPTH(`NN_BIAS_ROW + 1)) u_weight_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (weight_wr),
        .rd      (fetch_rd),
        .rd_data (weight_row)
    );

    fetch_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .clr          (clr),
        .fetch_rd     (fetch_rd),
        .mac_ctrl     (mac_ctrl),
        .scores_valid (scores_valid),
        .ready        (ready),
        .done         (done)
    );

    neuron_mac_array u_mac (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_row   (sample_row),
        .weight_row   (weight_row),
        .mac_ctrl     (mac_ctrl),
        .scores       (scores),
        .scores_valid (scores_valid)
    );

    result_buffer u_results (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (scores_valid),
        .wr_scores (scores),
        .rd_en     (result_rd_en),
        .rd_addr   (result_addr),
        .rd_data   (result_data)
    );

endmodule

`default_nettype wire

/* hdl/operand_bram.sv */
`default_nettype none

`include "nn_classifier_defines.svh"

module operand_bram #(
    parameter int DEPTH = `NN_BIAS_ROW + 1
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire nn_classifier_pkg::mem_wr_t wr,
    input  wire nn_classifier_pkg::mem_rd_t rd,
    output nn_classifier_pkg::row_t    rd_data
);
    import nn_classifier_pkg::*;

    logic [`NN_ROW_W-1:0] mem [DEPTH];
    logic [`NN_ROW_W-1:0] wr_bits;

    assign wr_bits = wr.data;   // Flat view for byte lanes

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
        begin
            for (int r = 0; r < DEPTH; r++)
                mem[r] <= '0;
        end
        else if (wr.en && (wr.addr < DEPTH))
        begin
            for (int b = 0; b < `NN_BYTES; b++)
                if (wr.byte_we[b])
                    mem[wr.addr][8*b +: 8] <= wr_bits[8*b +: 8];
        end
    end

    // Read port, old data on a same-address write
    // Out-of-range reads hold the last row (bias fetch on the sample side)
    always_ff @(posedge clk)
    begin
        if (rd.en && (rd.addr < DEPTH))
            rd_data <= mem[rd.addr];
    end

    // Host must stay inside the memory
    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr.en |-> (wr.addr < DEPTH));

endmodule

`default_nettype wire

/* hdl/result_buffer.sv */
`default_nettype none

`include "nn_classifier_defines.svh"

module result_buffer (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          wr_en,
    input  wire nn_classifier_pkg::row_t wr_scores,
    input  wire                          rd_en,
    input  wire nn_classifier_pkg::class_e rd_addr,
    output nn_classifier_pkg::lane_word_t rd_data
);
    import nn_classifier_pkg::*;

    lane_word_t entry [`NN_LANES];   // One score per class

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
        begin
            for (int i = 0; i < `NN_LANES; i++)
                entry[i] <= '0;
            rd_data <= '0;
        end
        else
        begin
            // All four lanes in one write
            if (wr_en)
            begin
                entry[DOS]      <= wr_scores.dos;
                entry[PORTSCAN] <= wr_scores.portscan;
                entry[DDOS]     <= wr_scores.ddos;
                entry[PATATOR]  <= wr_scores.patator;
            end
            if (rd_en)
                rd_data <= entry[rd_addr];   // Valid next cycle
        end
    end

endmodule

`default_nettype wire

/* nn_classifier.f */
+incdir+hdl
hdl/nn_classifier_pkg.sv
hdl/operand_bram.sv
hdl/fetch_sequencer.sv
hdl/neuron_mac_array.sv
hdl/result_buffer.sv
hdl/nn_classifier_top.sv
test/tb_nn_classifier.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the classifier testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_nn_classifier \
    -f nn_classifier.f

./obj_dir/Vtb_nn_classifier | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

/* test/tb_nn_classifier.sv */
`default_nettype none

`include "nn_classifier_defines.svh"

module tb_nn_classifier;
    import nn_classifier_pkg::*;

    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 60;    // Budget per test for the watchdog
    localparam int RUN_LATENCY  = 13;    // Start edge to done edge

    logic       clk;
    logic       rst_n;
    logic       clr;
    logic       start;
    logic       ready;
    logic       done;
    mem_wr_t    sample_wr;
    mem_wr_t    weight_wr;
    logic       result_rd_en;
    class_e     result_addr;
    lane_word_t result_data;

    row_t       smem [`NN_FEATURES];       // Mirror of the sample memory
    row_t       wmem [`NN_BIAS_ROW + 1];   // Mirror of weights plus bias row
    lane_word_t last_scores [`NN_LANES];   // Expected buffer contents
    int         val_errs;
    int         other_errs;
    int         checks;

    nn_classifier_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .clr          (clr),
        .start        (start),
        .ready        (ready),
        .done         (done),
        .sample_wr    (sample_wr),
        .weight_wr    (weight_wr),
        .result_rd_en (result_rd_en),
        .result_addr  (result_addr),
        .result_data  (result_data)
    );

    always #(PERIOD / 2) clk = ~clk;

    // Lane 0 in the top word
    function automatic lane_word_t get_lane(row_t r, int l);
        logic [`NN_ROW_W-1:0] bits;
        bits = r;
        return bits[`NN_ROW_W-1-l*`NN_WORD_W -: `NN_WORD_W];
    endfunction

    function automatic row_t put_lane(row_t r, int l, lane_word_t v);
        logic [`NN_ROW_W-1:0] bits;
        bits = r;
        bits[`NN_ROW_W-1-l*`NN_WORD_W -: `NN_WORD_W] = v;
        return bits;
    endfunction

    // Reference neuron, Q8.8 in, Q16.16 sum, ReLU and saturate out
    function automatic lane_word_t expected_score(int l);
        longint sum;
        sum = 0;
        for (int r = 0; r < `NN_FEATURES; r++)
            sum += longint'(get_lane(smem[r], l)) * longint'(get_lane(wmem[r], l));
        sum += longint'(get_lane(wmem[`NN_BIAS_ROW], l)) * 256;   // Bias to Q16.16
        sum = sum >>> `NN_FRAC_BITS;
        if (sum < 0)
            return '0;
        if (sum > 32767)
            return 16'sh7FFF;
        return lane_word_t'(sum);
    endfunction

    task automatic check_word(string name, lane_word_t exp, lane_word_t act);
        checks++;
        if (act !== exp)
        begin
            val_errs++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp)
        begin
            val_errs++;
            $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // Both memories in parallel, one row per cycle
    task automatic load_memories();
        for (int r = 0; r <= `NN_BIAS_ROW; r++)
        begin
            sample_wr.en      = (r < `NN_FEATURES);   // Sample side has no bias row
            sample_wr.byte_we = '1;
            sample_wr.addr    = `NN_ADDR_W'(r);
            if (r < `NN_FEATURES)
                sample_wr.data = smem[r];
            weight_wr.en      = 1'b1;
            weight_wr.byte_we = '1;
            weight_wr.addr    = `NN_ADDR_W'(r);
            weight_wr.data    = wmem[r];
            @(posedge clk);
            #1;
        end
        sample_wr.en = 1'b0;
        weight_wr.en = 1'b0;
    endtask

    task automatic write_sample_bytes(int addr, row_t data, logic [`NN_BYTES-1:0] be);
        logic [`NN_ROW_W-1:0] merged;
        logic [`NN_ROW_W-1:0] new_bits;
        merged   = smem[addr];
        new_bits = data;
        for (int b = 0; b < `NN_BYTES; b++)
            if (be[b])
                merged[8*b +: 8] = new_bits[8*b +: 8];   // Only enabled bytes
        smem[addr]        = merged;
        sample_wr.en      = 1'b1;
        sample_wr.byte_we = be;
        sample_wr.addr    = `NN_ADDR_W'(addr);
        sample_wr.data    = data;
        @(posedge clk);
        #1;
        sample_wr.en = 1'b0;
    endtask

    task automatic read_lane(class_e lane, output lane_word_t value);
        result_rd_en = 1'b1;
        result_addr  = lane;
        @(posedge clk);
        #1;
        result_rd_en = 1'b0;
        value = result_data;   // One cycle read latency
    endtask

    task automatic fill_random();
        for (int r = 0; r <= `NN_BIAS_ROW; r++)
            for (int l = 0; l < `NN_LANES; l++)
            begin
                if (r < `NN_FEATURES)   // Features within +-2.0
                    smem[r] = put_lane(smem[r], l, lane_word_t'(int'($urandom_range(1023)) - 512));
                wmem[r] = put_lane(wmem[r], l, lane_word_t'(int'($urandom_range(511)) - 256));
            end
    endtask

    // Start, time done, compare all four lanes against the model
    task automatic run_and_check(string tag);
        int         cycles;
        int         waited;
        lane_word_t got;
        waited = 0;
        while (!ready && waited < 20)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ready)
        begin
            other_errs++;
            $display("%s: DUT never returned to ready before start", tag);
        end
        start = 1'b1;
        @(posedge clk);
        #1;
        start  = 1'b0;
        cycles = 1;   // Counts the edge that samples done
        while (!done && cycles < 40)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done)
        begin
            other_errs++;
            $display("%s: no done pulse within 40 cycles of start", tag);
        end
        else if (cycles != RUN_LATENCY)
        begin
            other_errs++;
            $display("%s: done came %0d cycles after start, not %0d", tag, cycles, RUN_LATENCY);
        end
        for (int l = 0; l < `NN_LANES; l++)
        begin
            read_lane(class_e'(l), got);
            last_scores[l] = expected_score(l);
            check_word($sformatf("%s result_data[%0d]", tag, l), last_scores[l], got);
        end
    endtask

    task automatic test_reset();
        lane_word_t got;
        check_bit("ready", 1'b1, ready);
        check_bit("done", 1'b0, done);
        for (int l = 0; l < `NN_LANES; l++)
        begin
            last_scores[l] = '0;
            read_lane(class_e'(l), got);
            check_word($sformatf("reset result_data[%0d]", l), '0, got);
        end
    endtask

    // x = 1.0, w = (l+1)/16, bias 1.0, scores 400 544 688 832
    task automatic fill_directed();
        for (int r = 0; r <= `NN_BIAS_ROW; r++)
            for (int l = 0; l < `NN_LANES; l++)
            begin
                if (r < `NN_FEATURES)
                    smem[r] = put_lane(smem[r], l, 16'sh0100);
                if (r == `NN_BIAS_ROW)
                    wmem[r] = put_lane(wmem[r], l, 16'sh0100);
                else
                    wmem[r] = put_lane(wmem[r], l, lane_word_t'(16 * (l + 1)));
            end
    endtask

    task automatic test_directed();
        fill_directed();
        load_memories();
        run_and_check("directed");
    endtask

    // Three runs on fresh random operands
    task automatic test_random();
        repeat (3)
        begin
            fill_random();
            load_memories();
            run_and_check("random");
        end
    endtask

    task automatic test_saturation();
        for (int r = 0; r <= `NN_BIAS_ROW; r++)
            for (int l = 0; l < `NN_LANES; l++)
            begin
                if (r < `NN_FEATURES)
                    smem[r] = put_lane(smem[r], l, 16'sh7FFF);
                if (r == `NN_BIAS_ROW)
                    wmem[r] = put_lane(wmem[r], l, '0);
                else   // Patator lane goes hugely negative
                    wmem[r] = put_lane(wmem[r], l, (l == 3) ? 16'sh8000 : 16'sh7FFF);
            end
        load_memories();
        run_and_check("saturation");
    endtask

    task automatic test_partial_write();
        fill_directed();
        load_memories();
        // Low byte of patator in row 0, x becomes 0x01FF
        write_sample_bytes(0, row_t'(64'h1234_5678_9ABC_DEFF), 8'h01);
        run_and_check("partial write");
    endtask

    task automatic test_clear_abort();
        lane_word_t kept [`NN_LANES];
        lane_word_t got;
        kept = last_scores;
        fill_random();
        load_memories();
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        repeat (5)
        begin
            check_bit("done", 1'b0, done);
            @(posedge clk);
            #1;
        end
        clr = 1'b1;   // Abort in the middle of the fetch
        @(posedge clk);
        #1;
        clr = 1'b0;
        check_bit("ready", 1'b1, ready);
        repeat (16)
        begin
            check_bit("done", 1'b0, done);
            @(posedge clk);
            #1;
        end
        for (int l = 0; l < `NN_LANES; l++)
        begin
            read_lane(class_e'(l), got);
            check_word($sformatf("kept result_data[%0d]", l), kept[l], got);
        end
        run_and_check("after clr");
    endtask

    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        clr          = 1'b0;
        start        = 1'b0;
        sample_wr    = '0;
        weight_wr    = '0;
        result_rd_en = 1'b0;
        result_addr  = DOS;
        val_errs     = 0;
        other_errs   = 0;
        checks       = 0;
        void'($urandom(92));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset();
        test_directed();
        test_random();
        test_saturation();
        test_partial_write();
        test_clear_abort();

        $display("%0d checks, %0d value errors, %0d other errors", checks, val_errs, other_errs);
        if (val_errs + other_errs == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Whole run must fit the per-test budget
    initial
    begin
        #((RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
